// File: run.sh
#!/bin/sh
# Build and run the video pipeline testbench with Verilator

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
    --top-module video_top_tb -f vlog.f > "$LOG" 2>&1 \
    && ./obj_dir/Vvideo_top_tb >> "$LOG" 2>&1 \
    || echo "Test failed" >> "$LOG"

cat "$LOG"
if grep -q "Test failed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"
exit 0

// File: sim/video_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

module video_top_tb
    import pixel_pkg::*;
();

    localparam int H_ACTIVE = 32;
    localparam int H_FRONT  = 2;
    localparam int H_SYNC   = 4;
    localparam int H_BACK   = 2;
    localparam int V_ACTIVE = 12;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 1;
    localparam int TILE_SHIFT = 2;

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_AT    = H_ACTIVE + H_FRONT;
    localparam int V_SYNC_AT    = V_ACTIVE + V_FRONT;
    localparam int CLK_PERIOD   = 10;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int RUN_FRAMES   = CYCLE_COLORS + 3;  // Long enough to see the step wrap
    localparam int WATCHDOG_NS  = (RUN_FRAMES + 2) * FRAME_CYCLES * CLK_PERIOD;
    localparam int SEED         = 32'h1d189587;

    localparam rgb_t BKG_PAL [4] = '{24'h203040, 24'h304050, 24'h102030, 24'h405060};
    localparam rgb_t CYC_PAL [CYCLE_COLORS] = '{
        24'hFFFFFF, 24'hD8B000, 24'hF8F000, 24'hE9C22D, 24'hF2EDB1,
        24'h1F97D6, 24'h6B91AF, 24'h05518B, 24'hE6E3E3
    };
    localparam rgb_t SPR_PAL [SPRITE_COLORS] = '{
        24'h000000, 24'hF8F8F8, 24'h980000, 24'hD03800, 24'hF88058, 24'hA06800,
        24'h5888B8, 24'hD8B000, 24'hF8F000, 24'h6080A8, 24'hB8C8F0, 24'h303888,
        24'h8860B8, 24'h502898, 24'hB090D8, 24'h68F780
    };

    // Expected state of every output pin
    typedef struct packed {
        logic blank_n;
        logic hsync;
        logic vsync;
        rgb_t rgb;
    } pix_out_t;

    localparam pix_out_t IDLE_OUT = '{blank_n: 1'b0, hsync: 1'b1, vsync: 1'b1, rgb: '0};

    logic       VGA_CLK;
    logic       reset;
    logic       obj_load;
    obj_sel_t   obj_sel;
    obj_cfg_t   obj_cfg;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic       blank_n;
    logic       hsync;
    logic       vsync;

    obj_cfg_t pend_m [OBJ_NUM];  // Model of the loaded table
    obj_cfg_t live_m [OBJ_NUM];  // Model of the table being drawn
    int       cx;
    int       cy;
    int       frame_cnt;
    pix_out_t exp_s1;
    pix_out_t exp_s2;             // Lines up with the DUT outputs
    logic     checking = 1'b0;
    int       n_stack_px = 0;
    int       n_clear_px = 0;
    int       n_wrap_px = 0;

    video_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .TILE_SHIFT(TILE_SHIFT)
    ) video_top_i (
        .VGA_CLK(VGA_CLK), .reset(reset), .obj_load(obj_load), .obj_sel(obj_sel),
        .obj_cfg(obj_cfg), .red(red), .green(green), .blue(blue), .blank_n(blank_n),
        .hsync(hsync), .vsync(vsync)
    );

    initial begin
        VGA_CLK = 1'b0;
        forever #(CLK_PERIOD / 2) VGA_CLK = ~VGA_CLK;
    end

    function automatic logic inside_rect(obj_cfg_t o, int x, int y);
        logic in_x;
        logic in_y;
        in_x = (x >= int'(o.pos_x)) && (x < int'(o.pos_x) + int'(o.width));
        in_y = (y >= int'(o.pos_y)) && (y < int'(o.pos_y) + int'(o.height));
        return o.enable && in_x && in_y;
    endfunction

    function automatic logic shows(obj_cfg_t o, int x, int y);
        return inside_rect(o, x, y) && (o.index != '0);
    endfunction

    // First visible object in priority order, -1 for none
    function automatic int front_object(int x, int y);
        for (int i = 0; i < OBJ_NUM; i++) begin
            if (shows(live_m[i], x, y)) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int hit_count(int x, int y);
        int n;
        n = 0;
        for (int i = 0; i < OBJ_NUM; i++) begin
            if (shows(live_m[i], x, y)) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic logic clear_cover(int x, int y);
        for (int i = 0; i < OBJ_NUM; i++) begin
            if (inside_rect(live_m[i], x, y) && (live_m[i].index == '0)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic rgb_t background_color(int x, int y);
        int tile;
        tile = 2 * ((y >> TILE_SHIFT) & 1) + ((x >> TILE_SHIFT) & 1);
        return BKG_PAL[tile];
    endfunction

    function automatic rgb_t sprite_color(pal_index_t idx);
        int k;
        k = int'(idx);
        if (k > SPRITE_COLORS) begin
            return 24'h010101;
        end
        return SPR_PAL[k - 1];
    endfunction

    // Reference pixel model, two stages deep like the DUT
    always @(posedge VGA_CLK) begin
        int       fg;
        int       step;
        pix_out_t px;
        checking <= 1'b1;
        if (reset) begin
            for (int i = 0; i < OBJ_NUM; i++) begin
                pend_m[i] = '0;
                live_m[i] = '0;
            end
            cx        <= 0;
            cy        <= 0;
            frame_cnt <= 0;
            exp_s1    <= IDLE_OUT;
            exp_s2    <= IDLE_OUT;
        end else begin
            if (cx == 0 && cy == 0 && frame_cnt > 0) begin
                live_m = pend_m;  // Table swap at frame start
            end
            step       = frame_cnt % CYCLE_COLORS;
            fg         = front_object(cx, cy);
            px.hsync   = !(cx >= H_SYNC_AT && cx < H_SYNC_AT + H_SYNC);
            px.vsync   = !(cy >= V_SYNC_AT && cy < V_SYNC_AT + V_SYNC);
            px.blank_n = (cx < H_ACTIVE) && (cy < V_ACTIVE);
            if (!px.blank_n) begin
                px.rgb = '0;
            end else if (fg < 0) begin
                px.rgb = background_color(cx, cy);
            end else if (fg == ATTACK_OBJ) begin
                px.rgb = CYC_PAL[(int'(live_m[ATTACK_OBJ].index) + step - 1) % CYCLE_COLORS];
            end else begin
                px.rgb = sprite_color(live_m[fg].index);
            end
            if (px.blank_n) begin
                if (fg == ATTACK_OBJ && step == 0 && frame_cnt >= CYCLE_COLORS) begin
                    n_wrap_px <= n_wrap_px + 1;  // Cycling came back around
                end
                if (hit_count(cx, cy) > 1) begin
                    n_stack_px <= n_stack_px + 1;
                end
                if (clear_cover(cx, cy)) begin
                    n_clear_px <= n_clear_px + 1;
                end
            end
            if (obj_load) begin
                pend_m[obj_sel] = obj_cfg;
            end
            exp_s1 <= px;
            exp_s2 <= exp_s1;
            if (cx == H_TOTAL - 1) begin
                cx <= 0;
                if (cy == V_TOTAL - 1) begin
                    cy        <= 0;
                    frame_cnt <= frame_cnt + 1;
                end else begin
                    cy <= cy + 1;
                end
            end else begin
                cx <= cx + 1;
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [23:0] exp_val,
                                   input logic [23:0] act_val);
        $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
        $display("Test failed");
        $fatal(1, "Output mismatch on %s", name);
    endtask

    red_ok: assert property (@(posedge VGA_CLK)
        checking |-> red == exp_s2.rgb[23:16])
        else report_mismatch("red", 24'($sampled(exp_s2.rgb[23:16])), 24'($sampled(red)));
    green_ok: assert property (@(posedge VGA_CLK)
        checking |-> green == exp_s2.rgb[15:8])
        else report_mismatch("green", 24'($sampled(exp_s2.rgb[15:8])), 24'($sampled(green)));
    blue_ok: assert property (@(posedge VGA_CLK)
        checking |-> blue == exp_s2.rgb[7:0])
        else report_mismatch("blue", 24'($sampled(exp_s2.rgb[7:0])), 24'($sampled(blue)));
    blank_ok: assert property (@(posedge VGA_CLK)
        checking |-> blank_n == exp_s2.blank_n)
        else report_mismatch("blank_n", 24'($sampled(exp_s2.blank_n)), 24'($sampled(blank_n)));
    hsync_ok: assert property (@(posedge VGA_CLK)
        checking |-> hsync == exp_s2.hsync)
        else report_mismatch("hsync", 24'($sampled(exp_s2.hsync)), 24'($sampled(hsync)));
    vsync_ok: assert property (@(posedge VGA_CLK)
        checking |-> vsync == exp_s2.vsync)
        else report_mismatch("vsync", 24'($sampled(exp_s2.vsync)), 24'($sampled(vsync)));

    function automatic obj_cfg_t random_object(pal_index_t idx);
        obj_cfg_t o;
        o.enable = 1'b1;
        o.pos_x  = coord_t'(4 + $urandom % 16);
        o.pos_y  = coord_t'(1 + $urandom % 6);
        o.width  = coord_t'(4 + $urandom % 10);
        o.height = coord_t'(2 + $urandom % 5);
        o.index  = idx;
        return o;
    endfunction

    task automatic load_object(input int sel, input obj_cfg_t cfg);
        @(negedge VGA_CLK);
        obj_load = 1'b1;
        obj_sel  = obj_sel_t'(sel);
        obj_cfg  = cfg;
        @(negedge VGA_CLK);
        obj_load = 1'b0;
    endtask

    task automatic wait_frame(input int n);
        while (frame_cnt < n) begin
            @(negedge VGA_CLK);
        end
    endtask

    // Stacked objects around the player, one of them transparent
    task automatic place_objects();
        obj_cfg_t base;
        obj_cfg_t cfg;
        base = random_object(pal_index_t'(1 + $urandom % 16));
        load_object(PLAYER_OBJ, base);
        cfg       = base;
        cfg.pos_x = coord_t'(base.pos_x + 2);
        cfg.pos_y = coord_t'(base.pos_y + 1);
        cfg.index = pal_index_t'(1 + $urandom % 31);
        load_object(ATTACK_OBJ, cfg);
        cfg       = base;
        cfg.pos_x = coord_t'(base.pos_x + 3);
        cfg.index = pal_index_t'(17 + $urandom % 15);  // Past the sprite palette
        load_object(ENEMY_BASE, cfg);
        cfg       = base;
        cfg.pos_y = coord_t'(base.pos_y + 2);
        cfg.index = '0;
        load_object(ENEMY_BASE + 1, cfg);
        load_object(ENEMY_BASE + 2, random_object(pal_index_t'(1 + $urandom % 16)));
        load_object(ENEMY_BASE + 3, random_object(pal_index_t'(1 + $urandom % 20)));
    endtask

    initial begin
        obj_cfg_t cfg;
        void'($urandom(SEED));
        reset    = 1'b1;
        obj_load = 1'b0;
        obj_sel  = '0;
        obj_cfg  = '0;
        repeat (3) @(posedge VGA_CLK);
        @(negedge VGA_CLK);
        reset = 1'b0;

        wait_frame(1);                  // Frames 0 and 1 are background only
        repeat (50 + $urandom % 100) @(negedge VGA_CLK);
        place_objects();

        wait_frame(4);
        repeat (200 + $urandom % 200) @(negedge VGA_CLK);
        load_object(ATTACK_OBJ, random_object(pal_index_t'(1 + $urandom % 31)));

        wait_frame(7);
        repeat (100 + $urandom % 300) @(negedge VGA_CLK);
        cfg        = random_object(pal_index_t'(1 + $urandom % 16));
        cfg.enable = 1'b0;
        load_object(ENEMY_BASE + 2, cfg);

        wait_frame(RUN_FRAMES);
        repeat (4) @(negedge VGA_CLK);
        if (n_stack_px == 0 || n_clear_px == 0 || n_wrap_px == 0) begin
            $display("Stimulus missed a case: stacked %0d, transparent %0d, wrap %0d",
                     n_stack_px, n_clear_px, n_wrap_px);
            $display("Test failed");
            $fatal(1, "Incomplete stimulus");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the frame sequence finished");
        $display("Test failed");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

// File: source/background_layer.sv
`timescale 1ns/10ps
`default_nettype none

module background_layer
    import pixel_pkg::*;
#(
    parameter int TILE_SHIFT = 4
) (
    input  logic   VGA_CLK,
    input  logic   reset,
    input  coord_t pix_x,
    input  coord_t pix_y,
    output rgb_t   bkg_color
);

    pal_index_t tile_index;
    rgb_t       tile_color;

    // Four-tone check pattern, index 1 to 4
    always_comb begin
        tile_index = pal_index_t'(1)
                   + pal_index_t'({pix_y[TILE_SHIFT], 1'b0})
                   + pal_index_t'(pix_x[TILE_SHIFT]);
    end

    // Background palette
    always_comb begin
        case (tile_index)
            5'd1:    tile_color = 24'h203040;
            5'd2:    tile_color = 24'h304050;
            5'd3:    tile_color = 24'h102030;
            5'd4:    tile_color = 24'h405060;
            default: tile_color = 24'h000000;
        endcase
    end

    always_ff @(posedge VGA_CLK) begin
        if (reset) begin
            bkg_color <= '0;
        end else begin
            bkg_color <= tile_color; // Aligned with the sprite hits
        end
    end

endmodule

`default_nettype wire

// File: source/color_mapper.sv
`timescale 1ns/10ps
`default_nettype none

module color_mapper
    import pixel_pkg::*;
(
    input  logic        VGA_CLK,
    input  logic        reset,
    input  logic        frame_start,
    input  logic        active,
    input  rgb_t        bkg_color,
    input  layer_hits_t hits,
    output logic [7:0]  red,
    output logic [7:0]  green,
    output logic [7:0]  blue,
    output logic        blank_n
);

    logic [$clog2(CYCLE_COLORS)-1:0] step;   // Attack cycling phase

    logic       fg_hit;
    logic       fg_attack;
    pal_index_t fg_index;
    logic [5:0] cycle_sum;
    pal_index_t cycle_index;
    rgb_t       fg_color;
    rgb_t       pix_color;

    function automatic logic visible(obj_hit_t h);
        return h.hit && (h.index != '0);  // Index 0 shows what lies below
    endfunction

    function automatic rgb_t cycle_palette(pal_index_t idx);
        case (idx)
            5'd1:    return 24'hFFFFFF;
            5'd2:    return 24'hD8B000;
            5'd3:    return 24'hF8F000;
            5'd4:    return 24'hE9C22D;
            5'd5:    return 24'hF2EDB1;
            5'd6:    return 24'h1F97D6;
            5'd7:    return 24'h6B91AF;
            5'd8:    return 24'h05518B;
            5'd9:    return 24'hE6E3E3;
            default: return 24'h010101;
        endcase
    endfunction

    function automatic rgb_t sprite_palette(pal_index_t idx);
        case (idx)
            5'd1:    return 24'h000000;
            5'd2:    return 24'hF8F8F8;
            5'd3:    return 24'h980000;
            5'd4:    return 24'hD03800;
            5'd5:    return 24'hF88058;
            5'd6:    return 24'hA06800;
            5'd7:    return 24'h5888B8;
            5'd8:    return 24'hD8B000;
            5'd9:    return 24'hF8F000;
            5'd10:   return 24'h6080A8;
            5'd11:   return 24'hB8C8F0;
            5'd12:   return 24'h303888;
            5'd13:   return 24'h8860B8;
            5'd14:   return 24'h502898;
            5'd15:   return 24'hB090D8;
            5'd16:   return 24'h68F780;
            default: return 24'h010101;
        endcase
    endfunction

    // Step changes as the first pixel of a frame reaches the mapper
    always_ff @(posedge VGA_CLK) begin
        if (reset) begin
            step <= '0;
        end else if (frame_start) begin
            if (step == ($bits(step))'(CYCLE_COLORS - 1)) begin
                step <= '0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    // Fixed priority, attack first, last enemy lowest
    always_comb begin
        fg_hit    = 1'b0;
        fg_attack = 1'b0;
        fg_index  = '0;
        if (visible(hits.attack)) begin
            fg_hit    = 1'b1;
            fg_attack = 1'b1;
            fg_index  = hits.attack.index;
        end else if (visible(hits.player)) begin
            fg_hit   = 1'b1;
            fg_index = hits.player.index;
        end else begin
            for (int e = ENEMY_NUM - 1; e >= 0; e--) begin
                if (visible(hits.enemy[e])) begin
                    fg_hit   = 1'b1;
                    fg_index = hits.enemy[e].index;
                end
            end
        end
    end

    always_comb begin
        cycle_sum   = 6'(fg_index) + 6'(step) - 6'd1;   // fg_index is nonzero when used
        cycle_index = pal_index_t'((cycle_sum % 6'(CYCLE_COLORS)) + 6'd1);
        fg_color    = fg_attack ? cycle_palette(cycle_index) : sprite_palette(fg_index);
        pix_color   = fg_hit ? fg_color : bkg_color;
    end

    always_ff @(posedge VGA_CLK) begin
        if (reset) begin
            {red, green, blue} <= '0;
            blank_n            <= 1'b0;
        end else begin
            {red, green, blue} <= active ? pix_color : '0;
            blank_n            <= active;
        end
    end

    // Blanked pixels are black
    blank_is_black: assert property (
        @(posedge VGA_CLK) disable iff (reset)
        !blank_n |-> ({red, green, blue} == '0)
    );

endmodule

`default_nettype wire

// File: source/pixel_pkg.sv
`default_nettype none

package pixel_pkg;

    typedef logic [10:0] coord_t;      // Screen coordinate
    typedef logic [4:0]  pal_index_t;  // Palette index, 0 is transparent
    typedef logic [23:0] rgb_t;        // {red, green, blue}

    // Object table layout
    localparam int ENEMY_NUM  = 4;
    localparam int OBJ_NUM    = ENEMY_NUM + 2;
    localparam int ATTACK_OBJ = 0;
    localparam int PLAYER_OBJ = 1;
    localparam int ENEMY_BASE = 2;     // First enemy slot

    typedef logic [$clog2(OBJ_NUM)-1:0] obj_sel_t;

    // Palette sizes
    localparam int CYCLE_COLORS  = 9;  // Attack cycling palette
    localparam int SPRITE_COLORS = 16; // Regular sprite palette

    // One rectangular game object
    typedef struct packed {
        logic       enable;
        coord_t     pos_x;   // Top-left corner
        coord_t     pos_y;
        coord_t     width;
        coord_t     height;
        pal_index_t index;
    } obj_cfg_t;

    // Coverage of one object at the current pixel
    typedef struct packed {
        logic       hit;
        pal_index_t index;
    } obj_hit_t;

    // All objects at the current pixel, in priority order
    typedef struct packed {
        obj_hit_t                  attack;
        obj_hit_t                  player;
        obj_hit_t [ENEMY_NUM-1:0]  enemy;
    } layer_hits_t;

endpackage

`default_nettype wire

// File: source/sprite_layer.sv
`timescale 1ns/10ps
`default_nettype none

module sprite_layer
    import pixel_pkg::*;
(
    input  logic        VGA_CLK,
    input  logic        reset,
    input  coord_t      pix_x,
    input  coord_t      pix_y,
    input  logic        frame_start,
    input  logic        obj_load,
    input  obj_sel_t    obj_sel,
    input  obj_cfg_t    obj_cfg,
    output layer_hits_t hits
);

    obj_cfg_t    pending [OBJ_NUM];  // Written by loads during the frame
    obj_cfg_t    live    [OBJ_NUM];  // Drawn this frame
    obj_cfg_t    cur     [OBJ_NUM];
    obj_hit_t    obj_hit [OBJ_NUM];
    layer_hits_t hits_next;

    // Rectangle test, sums one bit wider so edge objects do not wrap
    function automatic logic covers(obj_cfg_t o, coord_t x, coord_t y);
        logic [11:0] x_end;
        logic [11:0] y_end;
        logic        in_x;
        logic        in_y;
        x_end = {1'b0, o.pos_x} + {1'b0, o.width};
        y_end = {1'b0, o.pos_y} + {1'b0, o.height};
        in_x  = (x >= o.pos_x) && ({1'b0, x} < x_end);
        in_y  = (y >= o.pos_y) && ({1'b0, y} < y_end);
        return o.enable && in_x && in_y && (o.index != '0);
    endfunction

    always_ff @(posedge VGA_CLK) begin
        if (reset) begin
            for (int i = 0; i < OBJ_NUM; i++) begin
                pending[i] <= '0;
                live[i]    <= '0;
            end
        end else begin
            if (obj_load && (obj_sel < obj_sel_t'(OBJ_NUM))) begin
                pending[obj_sel] <= obj_cfg;
            end
            if (frame_start) begin
                for (int i = 0; i < OBJ_NUM; i++) begin
                    live[i] <= pending[i];
                end
            end
        end
    end

    // Pixel (0,0) is tested while the swap is still in flight
    always_comb begin
        for (int i = 0; i < OBJ_NUM; i++) begin
            cur[i] = frame_start ? pending[i] : live[i];
        end
    end

    always_comb begin
        for (int i = 0; i < OBJ_NUM; i++) begin
            obj_hit[i].hit   = covers(cur[i], pix_x, pix_y);
            obj_hit[i].index = cur[i].index;
        end
    end

    // Pack into priority order
    always_comb begin
        hits_next.attack = obj_hit[ATTACK_OBJ];
        hits_next.player = obj_hit[PLAYER_OBJ];
        for (int e = 0; e < ENEMY_NUM; e++) begin
            hits_next.enemy[e] = obj_hit[ENEMY_BASE + e];
        end
    end

    always_ff @(posedge VGA_CLK) begin
        if (reset) begin
            hits <= '0;
        end else begin
            hits <= hits_next;
        end
    end

    // Loads only address existing entries
    obj_sel_in_range: assert property (
        @(posedge VGA_CLK) disable iff (reset)
        obj_load |-> (obj_sel < obj_sel_t'(OBJ_NUM))
    );

endmodule

`default_nettype wire

// File: source/vga_timing.sv
`timescale 1ns/10ps
`default_nettype none

module vga_timing
    import pixel_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic   VGA_CLK,
    input  logic   reset,
    output coord_t pix_x,
    output coord_t pix_y,
    output logic   active,
    output logic   hsync,
    output logic   vsync,
    output logic   frame_start
);

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    coord_t h_cnt;
    coord_t v_cnt;
    logic   h_last;
    logic   v_last;

    assign h_last = (h_cnt == coord_t'(H_TOTAL - 1));
    assign v_last = (v_cnt == coord_t'(V_TOTAL - 1));

    always_ff @(posedge VGA_CLK) begin
        if (reset) begin
            h_cnt       <= '0;
            v_cnt       <= '0;
            frame_start <= 1'b0;
        end else begin
            frame_start <= h_last && v_last; // Counters hit (0,0) next cycle
            if (h_last) begin
                h_cnt <= '0;
                if (v_last) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    assign pix_x = h_cnt;
    assign pix_y = v_cnt;

    // Sync pulses sit right after the front porch, active low
    assign hsync = !((h_cnt >= coord_t'(H_SYNC_START)) && (h_cnt < coord_t'(H_SYNC_END)));
    assign vsync = !((v_cnt >= coord_t'(V_SYNC_START)) && (v_cnt < coord_t'(V_SYNC_END)));

    assign active = (h_cnt < coord_t'(H_ACTIVE)) && (v_cnt < coord_t'(V_ACTIVE));

    // One pulse per frame, never back to back
    frame_start_single: assert property (
        @(posedge VGA_CLK) disable iff (reset)
        frame_start |=> !frame_start
    );

endmodule

`default_nettype wire

// File: source/video_top.sv
`timescale 1ns/10ps
`default_nettype none

module video_top
    import pixel_pkg::*;
#(
    parameter int H_ACTIVE   = 640,
    parameter int H_FRONT    = 16,
    parameter int H_SYNC     = 96,
    parameter int H_BACK     = 48,
    parameter int V_ACTIVE   = 480,
    parameter int V_FRONT    = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 33,
    parameter int TILE_SHIFT = 4
) (
    input  logic       VGA_CLK,
    input  logic       reset,
    input  logic       obj_load,
    input  obj_sel_t   obj_sel,
    input  obj_cfg_t   obj_cfg,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue,
    output logic       blank_n,
    output logic       hsync,
    output logic       vsync
);

    coord_t      pix_x;
    coord_t      pix_y;
    logic        active;
    logic        active_d;      // Aligned with the layer outputs
    logic        hsync_raw;
    logic        vsync_raw;
    logic [1:0]  hsync_pipe;
    logic [1:0]  vsync_pipe;
    logic        frame_start;
    rgb_t        bkg_color;
    layer_hits_t hits;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) vga_timing_i (
        .VGA_CLK(VGA_CLK), .reset(reset), .pix_x(pix_x), .pix_y(pix_y), .active(active),
        .hsync(hsync_raw), .vsync(vsync_raw), .frame_start(frame_start)
    );

    background_layer #(.TILE_SHIFT(TILE_SHIFT)) background_layer_i (
        .VGA_CLK(VGA_CLK), .reset(reset), .pix_x(pix_x), .pix_y(pix_y), .bkg_color(bkg_color)
    );

    sprite_layer sprite_layer_i (
        .VGA_CLK(VGA_CLK), .reset(reset), .pix_x(pix_x), .pix_y(pix_y),
        .frame_start(frame_start), .obj_load(obj_load), .obj_sel(obj_sel),
        .obj_cfg(obj_cfg), .hits(hits)
    );

    color_mapper color_mapper_i (
        .VGA_CLK(VGA_CLK), .reset(reset), .frame_start(frame_start), .active(active_d),
        .bkg_color(bkg_color), .hits(hits), .red(red), .green(green), .blue(blue),
        .blank_n(blank_n)
    );

    // Syncs follow the two pixel stages
    always_ff @(posedge VGA_CLK) begin
        if (reset) begin
            active_d   <= 1'b0;
            hsync_pipe <= 2'b11;
            vsync_pipe <= 2'b11;
        end else begin
            active_d   <= active;
            hsync_pipe <= {hsync_pipe[0], hsync_raw};
            vsync_pipe <= {vsync_pipe[0], vsync_raw};
        end
    end

    assign hsync = hsync_pipe[1];
    assign vsync = vsync_pipe[1];

endmodule

`default_nettype wire

// File: vlog.f
source/pixel_pkg.sv
source/vga_timing.sv
source/background_layer.sv
source/sprite_layer.sv
source/color_mapper.sv
source/video_top.sv
sim/video_top_tb.sv
